/* Makefile */
# Verilator lint, simulation and clean for the key-value table

VERILATOR ?= verilator
TOP       ?= kv_db_tb
RTL_TOP   ?= kv_db_top
FILELIST  ?= kv_db.f
RTL_SRCS  ?= kv_db_pkg.sv kv_db_store.sv kv_db_prio_arb.sv kv_db_top.sv
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= ** PASS **
FAIL_MSG  ?= ** FAIL **

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF -- '$(FAIL_MSG)' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF -- '$(PASS_MSG)' $(LOG); then echo "No result in $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* kv_db.f */
kv_db_pkg.sv
kv_db_store.sv
kv_db_prio_arb.sv
kv_db_top.sv
kv_db_assertions.sv
kv_db_checker.sv
kv_db_tb.sv

/* kv_db_assertions.sv */
// Arbiter protocol assertions, bound into every kv_db_prio_arb instance by the bind at the end
`timescale 1ns/100ps

module kv_db_assertions (
    input logic clk,
    input logic srst,
    input logic hi_req,
    input logic hi_rdy,
    input logic hi_ack,
    input logic lo_req,
    input logic lo_rdy,
    input logic lo_ack,
    input logic st_req,
    input logic st_rdy
);

    int   fail_count;

    // Accepted transaction not yet acked, and the port that owns it
    logic open;
    logic owner_lo;

    always_ff @(posedge clk) begin
        if (srst) begin
            open     <= 1'b0;
            owner_lo <= 1'b0;
        end else if (hi_ack || lo_ack) begin
            open <= 1'b0;
        end else if (hi_req && hi_rdy) begin
            open     <= 1'b1;
            owner_lo <= 1'b0;
        end else if (lo_req && lo_rdy) begin
            open     <= 1'b1;
            owner_lo <= 1'b1;
        end
    end

    // Each ack goes to the port that owns the open transaction, so never to both
    hi_ack_to_owner: assert property (@(posedge clk) disable iff (srst)
                                      hi_ack |-> open && !owner_lo)
        else begin
            $error("hi_ack without an open hi transaction");
            fail_count++;
        end

    lo_ack_to_owner: assert property (@(posedge clk) disable iff (srst)
                                      lo_ack |-> open && owner_lo)
        else begin
            $error("lo_ack without an open lo transaction");
            fail_count++;
        end

    // At most one port sees rdy, and none while a transaction is open
    rdys_exclusive: assert property (@(posedge clk) disable iff (srst)
                                     $onehot0({hi_rdy, lo_rdy, open}))
        else begin
            $error("rdy offered to both ports or during an open transaction");
            fail_count++;
        end

    // Selected request must wait for the store to take it
    st_req_held: assert property (@(posedge clk) disable iff (srst) st_req && !st_rdy |=> st_req)
        else begin
            $error("st_req dropped before st_rdy");
            fail_count++;
        end

endmodule : kv_db_assertions

bind kv_db_prio_arb kv_db_assertions u_assertions (
    .clk    (clk),
    .srst   (srst),
    .hi_req (hi_req),
    .hi_rdy (hi_rdy),
    .hi_ack (hi_ack),
    .lo_req (lo_req),
    .lo_rdy (lo_rdy),
    .lo_ack (lo_ack),
    .st_req (st_req),
    .st_rdy (st_rdy)
);

/* kv_db_checker.sv */
// Testbench checker: keeps a model table, matches each ack to its accepted request and compares
`timescale 1ns/100ps

module kv_db_checker #(
    parameter int KEY_W   = kv_db_pkg::KEY_W_DEFAULT,
    parameter int VALUE_W = kv_db_pkg::VALUE_W_DEFAULT
) (
    input  logic                clk,
    input  logic                srst,
    input  logic                hi_req,
    input  kv_db_pkg::command_t hi_command,
    input  logic [KEY_W-1:0]    hi_key,
    input  logic [VALUE_W-1:0]  hi_set_value,
    input  logic                hi_rdy,
    input  logic                hi_ack,
    input  logic                lo_req,
    input  kv_db_pkg::command_t lo_command,
    input  logic [KEY_W-1:0]    lo_key,
    input  logic [VALUE_W-1:0]  lo_set_value,
    input  logic                lo_rdy,
    input  logic                lo_ack,
    input  kv_db_pkg::status_t  status,
    input  logic                get_valid,
    input  logic [KEY_W-1:0]    get_key,
    input  logic [VALUE_W-1:0]  get_value,
    output int                  checks_done,
    output int                  error_count
);

    localparam int DEPTH = 2**KEY_W;

    // Model table, empty after reset
    logic                model_valid [DEPTH];
    logic [VALUE_W-1:0]  model_value [DEPTH];

    // Accepted requests in order of acceptance
    bit                  q_lo [$];
    kv_db_pkg::command_t q_cmd [$];
    logic [KEY_W-1:0]    q_key [$];
    logic [VALUE_W-1:0]  q_val [$];
    int                  q_cycle [$];
    int                  cycle;

    // Lo asked while the peripheral was free and hi idle, so lo owns it
    bit                  lo_claim;

    task automatic record(input bit lo, input kv_db_pkg::command_t cmd,
                          input logic [KEY_W-1:0] k, input logic [VALUE_W-1:0] v);
        q_lo.push_back(lo);
        q_cmd.push_back(cmd);
        q_key.push_back(k);
        q_val.push_back(v);
        q_cycle.push_back(cycle);
    endtask

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp,
                           inout bit ok);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
            ok = 1'b0;
        end
    endtask

    task automatic check_response(input bit lo_port);
        bit                  ok;
        bit                  lo;
        kv_db_pkg::command_t cmd;
        logic [KEY_W-1:0]    k;
        logic [VALUE_W-1:0]  v;
        int                  latency;
        int                  exp_latency;
        ok = 1'b1;
        if (q_cmd.size() == 0) begin
            $display("Error at %0t: ack on the %s port with no accepted request", $time,
                     lo_port ? "lo" : "hi");
            error_count++;
            return;
        end
        lo = q_lo.pop_front();
        cmd = q_cmd.pop_front();
        k = q_key.pop_front();
        v = q_val.pop_front();
        latency = cycle - q_cycle.pop_front();
        // CLEAR sweeps every row before it answers
        exp_latency = (cmd == kv_db_pkg::COMMAND_CLEAR) ? DEPTH + 1 : 2;
        if (lo != lo_port) begin
            $display("Error at %0t: ack went to the %s port, request came from the other one",
                     $time, lo_port ? "lo" : "hi");
            ok = 1'b0;
        end
        if (latency != exp_latency) begin
            $display("Error at %0t: ack came %0d cycles after acceptance, expected %0d",
                     $time, latency, exp_latency);
            ok = 1'b0;
        end
        case (cmd)
            kv_db_pkg::COMMAND_GET,
            kv_db_pkg::COMMAND_SET,
            kv_db_pkg::COMMAND_UNSET: begin
                compare("status", 64'(status), 64'(kv_db_pkg::STATUS_OK), ok);
                compare("get_valid", 64'(get_valid), 64'(model_valid[k]), ok);
                compare("get_key", 64'(get_key), 64'(k), ok);
                if (model_valid[k]) begin
                    compare("get_value", 64'(get_value), 64'(model_value[k]), ok);
                end
                // Previous entry is reported before the write
                if (cmd == kv_db_pkg::COMMAND_SET) begin
                    model_valid[k] = 1'b1;
                    model_value[k] = v;
                end else if (cmd == kv_db_pkg::COMMAND_UNSET) begin
                    model_valid[k] = 1'b0;
                end
            end
            kv_db_pkg::COMMAND_CLEAR: begin
                compare("status", 64'(status), 64'(kv_db_pkg::STATUS_OK), ok);
                compare("get_valid", 64'(get_valid), 64'd0, ok);
                foreach (model_valid[i]) begin
                    model_valid[i] = 1'b0;
                end
            end
            default: begin
                compare("status", 64'(status), 64'(kv_db_pkg::STATUS_ERROR), ok);
            end
        endcase
        checks_done++;
        if (!ok) begin
            error_count++;
        end
        $display("Test %0d: %s %s key %0d %s", checks_done, lo ? "lo" : "hi", cmd.name(), k,
                 ok ? "ok" : "mismatch");
    endtask

    always @(posedge clk) begin
        if (srst) begin
            foreach (model_valid[i]) begin
                model_valid[i] = 1'b0;
            end
            q_lo.delete();
            q_cmd.delete();
            q_key.delete();
            q_val.delete();
            q_cycle.delete();
            cycle = 0;
            lo_claim = 1'b0;
        end else begin
            cycle++;
            // Ownership is decided only while no transaction is outstanding
            if (q_cmd.size() == 0 && lo_req && !hi_req) begin
                lo_claim = 1'b1;
            end
            if (hi_ack && lo_ack) begin
                $display("Error at %0t: hi_ack and lo_ack are high together", $time);
                error_count++;
            end else if (hi_ack || lo_ack) begin
                check_response(lo_ack);
            end
            if (hi_req && hi_rdy) begin
                record(1'b0, hi_command, hi_key, hi_set_value);
            end
            if (lo_req && lo_rdy) begin
                if (hi_req && !lo_claim) begin
                    $display("Error at %0t: lo request served ahead of a waiting hi request",
                             $time);
                    error_count++;
                end
                lo_claim = 1'b0;
                record(1'b1, lo_command, lo_key, lo_set_value);
            end
        end
    end

endmodule : kv_db_checker

/* kv_db_pkg.sv */
// Shared command and status encodings and default widths for the key-value table design
package kv_db_pkg;

    // ==============================
    // Default widths
    // ==============================

    // One table row per key value, so the table holds 2**KEY_W rows
    localparam int KEY_W_DEFAULT   = 6;
    localparam int VALUE_W_DEFAULT = 32;

    // ==============================
    // Request commands
    // ==============================

    // GET    returns the stored entry
    // SET    returns the previous entry, then writes the new value
    // UNSET  returns the previous entry, then invalidates the row
    // CLEAR  invalidates every row
    typedef enum logic [2:0] {
        COMMAND_NOP   = 3'd0,
        COMMAND_GET   = 3'd1,
        COMMAND_SET   = 3'd2,
        COMMAND_UNSET = 3'd3,
        COMMAND_CLEAR = 3'd4
    } command_t;

    // ==============================
    // Response status
    // ==============================

    // UNSPECIFIED is shown outside ack cycles
    typedef enum logic [1:0] {
        STATUS_OK          = 2'd0,
        STATUS_ERROR       = 2'd1,
        STATUS_UNSPECIFIED = 2'd2
    } status_t;

endpackage : kv_db_pkg

/* kv_db_prio_arb.sv */
// Strict-priority arbiter giving one table peripheral to the hi or lo controller until its ack
`timescale 1ns/100ps

module kv_db_prio_arb #(
    parameter int KEY_W   = kv_db_pkg::KEY_W_DEFAULT,
    parameter int VALUE_W = kv_db_pkg::VALUE_W_DEFAULT
) (
    input  logic                clk,
    input  logic                srst,
    // High-priority controller
    input  logic                hi_req,
    input  kv_db_pkg::command_t hi_command,
    input  logic [KEY_W-1:0]    hi_key,
    input  logic [VALUE_W-1:0]  hi_set_value,
    output logic                hi_rdy,
    output logic                hi_ack,
    // Low-priority controller
    input  logic                lo_req,
    input  kv_db_pkg::command_t lo_command,
    input  logic [KEY_W-1:0]    lo_key,
    input  logic [VALUE_W-1:0]  lo_set_value,
    output logic                lo_rdy,
    output logic                lo_ack,
    // Peripheral side
    output logic                st_req,
    output kv_db_pkg::command_t st_command,
    output logic [KEY_W-1:0]    st_key,
    output logic [VALUE_W-1:0]  st_set_value,
    input  logic                st_rdy,
    input  logic                st_ack,
    input  kv_db_pkg::status_t  st_status,
    input  logic                st_get_valid,
    input  logic [KEY_W-1:0]    st_get_key,
    input  logic [VALUE_W-1:0]  st_get_value,
    // Response shared by both controllers
    output kv_db_pkg::status_t  status,
    output logic                get_valid,
    output logic [KEY_W-1:0]    get_key,
    output logic [VALUE_W-1:0]  get_value
);

    // ==============================
    // Grant
    // ==============================

    // High when the lo controller owns the peripheral
    logic sel_lo;
    logic sel_lo_reg;
    logic pending;

    // Free choice only between transactions, hi wins a tie
    always_comb begin
        if (pending) begin
            sel_lo = sel_lo_reg;
        end else begin
            sel_lo = !hi_req;
        end
    end

    // Transaction stays open from the selected req until the peripheral's ack
    always_ff @(posedge clk) begin
        if (srst) begin
            pending <= 1'b0;
        end else if (st_ack) begin
            pending <= 1'b0;
        end else if (st_req) begin
            pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            sel_lo_reg <= 1'b0;
        end else begin
            sel_lo_reg <= sel_lo;
        end
    end

    // ==============================
    // Request mux
    // ==============================

    assign st_req       = sel_lo ? lo_req       : hi_req;
    assign st_command   = sel_lo ? lo_command   : hi_command;
    assign st_key       = sel_lo ? lo_key       : hi_key;
    assign st_set_value = sel_lo ? lo_set_value : hi_set_value;

    // ==============================
    // Response demux
    // ==============================

    // Only the selected controller sees the strobes
    assign hi_rdy = st_rdy && !sel_lo;
    assign hi_ack = st_ack && !sel_lo;
    assign lo_rdy = st_rdy && sel_lo;
    assign lo_ack = st_ack && sel_lo;

    assign status    = st_status;
    assign get_valid = st_get_valid;
    assign get_key   = st_get_key;
    assign get_value = st_get_value;

endmodule : kv_db_prio_arb

/* kv_db_store.sv */
// Key-value table peripheral, one row per key; clears itself after reset and serves one request at a time
`timescale 1ns/100ps

module kv_db_store #(
    parameter int KEY_W   = kv_db_pkg::KEY_W_DEFAULT,
    parameter int VALUE_W = kv_db_pkg::VALUE_W_DEFAULT
) (
    input  logic                clk,
    input  logic                srst,
    input  logic                req,
    input  kv_db_pkg::command_t command,
    input  logic [KEY_W-1:0]    key,
    input  logic [VALUE_W-1:0]  set_value,
    output logic                rdy,
    output logic                ack,
    output kv_db_pkg::status_t  status,
    output logic                get_valid,
    output logic [KEY_W-1:0]    get_key,
    output logic [VALUE_W-1:0]  get_value
);

    localparam int DEPTH = 2**KEY_W;

    // FSM state encodings
    localparam logic [2:0] ST_INIT_CLEAR  = 3'd0;
    localparam logic [2:0] ST_IDLE        = 3'd1;
    localparam logic [2:0] ST_READ        = 3'd2;
    localparam logic [2:0] ST_RESPOND     = 3'd3;
    localparam logic [2:0] ST_CLEAR_SWEEP = 3'd4;

    // ==============================
    // Signals
    // ==============================

    logic [2:0]          state;
    logic [2:0]          state_nxt;
    logic                accept;

    // Row pointer shared by the init clear and the CLEAR sweep
    logic [KEY_W-1:0]    sweep_addr;
    logic                sweep_last;
    logic                sweeping;

    // Request captured on acceptance
    kv_db_pkg::command_t cmd_reg;
    logic [KEY_W-1:0]    key_reg;
    logic [VALUE_W-1:0]  value_reg;

    // Table storage
    logic                valid_mem [DEPTH];
    logic [VALUE_W-1:0]  value_mem [DEPTH];
    logic                rd_valid;
    logic [VALUE_W-1:0]  rd_value;

    // Single write port
    logic                wr_en;
    logic [KEY_W-1:0]    wr_addr;
    logic                wr_valid;
    logic [VALUE_W-1:0]  wr_value;

    // ==============================
    // Request acceptance
    // ==============================

    assign rdy    = (state == ST_IDLE);
    assign accept = req && rdy;

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_reg   <= command;
            key_reg   <= key;
            value_reg <= set_value;
        end
    end

    // ==============================
    // FSM
    // ==============================

    always_comb begin
        state_nxt = state;
        case (state)
            ST_INIT_CLEAR: begin
                if (sweep_last) begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_IDLE: begin
                if (accept) begin
                    // CLEAR skips the row read and goes straight to the sweep
                    if (command == kv_db_pkg::COMMAND_CLEAR) begin
                        state_nxt = ST_CLEAR_SWEEP;
                    end else begin
                        state_nxt = ST_READ;
                    end
                end
            end
            ST_READ: begin
                state_nxt = ST_RESPOND;
            end
            ST_RESPOND: begin
                state_nxt = ST_IDLE;
            end
            ST_CLEAR_SWEEP: begin
                if (sweep_last) begin
                    state_nxt = ST_RESPOND;
                end
            end
            default: begin
                state_nxt = ST_INIT_CLEAR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            state <= ST_INIT_CLEAR;
        end else begin
            state <= state_nxt;
        end
    end

    // Sweep pointer wraps back to zero after the last row
    assign sweeping   = (state == ST_INIT_CLEAR) || (state == ST_CLEAR_SWEEP);
    assign sweep_last = &sweep_addr;

    always_ff @(posedge clk) begin
        if (srst) begin
            sweep_addr <= '0;
        end else if (sweeping) begin
            sweep_addr <= sweep_addr + 1'b1;
        end
    end

    // ==============================
    // Table
    // ==============================

    // Sweeps invalidate one row per cycle; SET and UNSET write in the respond cycle
    always_comb begin
        wr_en    = 1'b0;
        wr_addr  = sweep_addr;
        wr_valid = 1'b0;
        wr_value = '0;
        if (sweeping) begin
            wr_en = 1'b1;
        end else if (state == ST_RESPOND) begin
            wr_addr = key_reg;
            if (cmd_reg == kv_db_pkg::COMMAND_SET) begin
                wr_en    = 1'b1;
                wr_valid = 1'b1;
                wr_value = value_reg;
            end else if (cmd_reg == kv_db_pkg::COMMAND_UNSET) begin
                wr_en = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            valid_mem[wr_addr] <= wr_valid;
            value_mem[wr_addr] <= wr_value;
        end
    end

    // Previous entry is read in the cycle after acceptance
    always_ff @(posedge clk) begin
        if (state == ST_READ) begin
            rd_valid <= valid_mem[key_reg];
            rd_value <= value_mem[key_reg];
        end
    end

    // ==============================
    // Response
    // ==============================

    always_comb begin
        ack       = 1'b0;
        status    = kv_db_pkg::STATUS_UNSPECIFIED;
        get_valid = 1'b0;
        if (state == ST_RESPOND) begin
            ack = 1'b1;
            case (cmd_reg)
                kv_db_pkg::COMMAND_GET,
                kv_db_pkg::COMMAND_SET,
                kv_db_pkg::COMMAND_UNSET: begin
                    status    = kv_db_pkg::STATUS_OK;
                    get_valid = rd_valid;
                end
                kv_db_pkg::COMMAND_CLEAR: begin
                    status = kv_db_pkg::STATUS_OK;
                end
                default: begin
                    status = kv_db_pkg::STATUS_ERROR;
                end
            endcase
        end
    end

    assign get_key   = key_reg;
    assign get_value = get_valid ? rd_value : '0;

endmodule : kv_db_store

/* kv_db_tb.sv */
// Testbench top for the key-value table: directed and seeded random requests on both ports
`timescale 1ns/100ps

module kv_db_tb;

    localparam int KEY_W      = 4;
    localparam int VALUE_W    = 32;
    localparam int CLK_PERIOD = 8;
    localparam int KEY_RANGE  = 8;
    localparam int WAIT_LIMIT = 500;
    localparam int RANDOM_OPS = 60;

    logic                clk;
    logic                srst;
    logic                hi_req;
    kv_db_pkg::command_t hi_command;
    logic [KEY_W-1:0]    hi_key;
    logic [VALUE_W-1:0]  hi_set_value;
    logic                hi_rdy;
    logic                hi_ack;
    logic                lo_req;
    kv_db_pkg::command_t lo_command;
    logic [KEY_W-1:0]    lo_key;
    logic [VALUE_W-1:0]  lo_set_value;
    logic                lo_rdy;
    logic                lo_ack;
    kv_db_pkg::status_t  status;
    logic                get_valid;
    logic [KEY_W-1:0]    get_key;
    logic [VALUE_W-1:0]  get_value;
    int                  checks_done;
    int                  error_count;
    int                  timeouts;

    kv_db_top #(.KEY_W(KEY_W), .VALUE_W(VALUE_W)) UUT (.*);

    kv_db_checker #(.KEY_W(KEY_W), .VALUE_W(VALUE_W)) u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic drive_port(input bit is_lo, input logic req, input kv_db_pkg::command_t cmd,
                              input logic [KEY_W-1:0] k, input logic [VALUE_W-1:0] v);
        if (is_lo) begin
            lo_req       = req;
            lo_command   = cmd;
            lo_key       = k;
            lo_set_value = v;
        end else begin
            hi_req       = req;
            hi_command   = cmd;
            hi_key       = k;
            hi_set_value = v;
        end
    endtask

    // One request on one port: raise req, hold until accepted, then wait for the ack
    task automatic issue(input bit is_lo, input kv_db_pkg::command_t cmd,
                         input logic [KEY_W-1:0] k, input logic [VALUE_W-1:0] v);
        int cnt;
        bit seen;
        if (timeouts != 0) begin
            return;
        end
        @(negedge clk);
        drive_port(is_lo, 1'b1, cmd, k, v);
        cnt = 0;
        seen = 1'b0;
        // rdy is sampled 1 ns before the rising edge
        while (!seen && cnt < WAIT_LIMIT) begin
            #(CLK_PERIOD/2 - 1);
            seen = is_lo ? lo_rdy : hi_rdy;
            @(negedge clk);
            cnt++;
        end
        drive_port(is_lo, 1'b0, kv_db_pkg::COMMAND_NOP, '0, '0);
        if (!seen) begin
            $display("Timeout: %s port waited %0d cycles for rdy", is_lo ? "lo" : "hi", cnt);
            timeouts++;
            return;
        end
        cnt = 0;
        seen = 1'b0;
        while (!seen && cnt < WAIT_LIMIT) begin
            #(CLK_PERIOD/2 - 1);
            seen = is_lo ? lo_ack : hi_ack;
            @(negedge clk);
            cnt++;
        end
        if (!seen) begin
            $display("Timeout: %s port waited %0d cycles for ack", is_lo ? "lo" : "hi", cnt);
            timeouts++;
        end
    endtask

    // Mostly GET and SET so that keys hit, now and then a NOP or a CLEAR
    task automatic pick(output kv_db_pkg::command_t cmd, output logic [KEY_W-1:0] k,
                        output logic [VALUE_W-1:0] v, output int gap);
        int r;
        r = $urandom_range(0, 19);
        if (r < 8) begin
            cmd = kv_db_pkg::COMMAND_GET;
        end else if (r < 14) begin
            cmd = kv_db_pkg::COMMAND_SET;
        end else if (r < 18) begin
            cmd = kv_db_pkg::COMMAND_UNSET;
        end else if (r == 18) begin
            cmd = kv_db_pkg::COMMAND_NOP;
        end else begin
            cmd = kv_db_pkg::COMMAND_CLEAR;
        end
        k = KEY_W'($urandom_range(0, KEY_RANGE - 1));
        v = VALUE_W'($urandom());
        gap = $urandom_range(0, 3);
    endtask

    initial begin
        kv_db_pkg::command_t hi_cmd;
        kv_db_pkg::command_t lo_cmd;
        logic [KEY_W-1:0]    hi_k;
        logic [KEY_W-1:0]    lo_k;
        logic [VALUE_W-1:0]  hi_v;
        logic [VALUE_W-1:0]  lo_v;
        int                  hi_gap;
        int                  lo_gap;
        int                  assert_fails;
        void'($urandom(44));
        srst = 1'b1;
        drive_port(1'b0, 1'b0, kv_db_pkg::COMMAND_NOP, '0, '0);
        drive_port(1'b1, 1'b0, kv_db_pkg::COMMAND_NOP, '0, '0);
        repeat (2) @(negedge clk);
        srst = 1'b0;

        // ==============================
        // Directed sequences
        // ==============================

        // Table is empty once the init clear is done
        for (int i = 0; i < 2**KEY_W; i++) begin
            issue(1'b0, kv_db_pkg::COMMAND_GET, KEY_W'(i), '0);
        end
        issue(1'b0, kv_db_pkg::COMMAND_SET, KEY_W'(3), 32'h1234_5678);
        issue(1'b1, kv_db_pkg::COMMAND_SET, KEY_W'(3), 32'h0bad_cafe);
        issue(1'b0, kv_db_pkg::COMMAND_GET, KEY_W'(3), '0);
        issue(1'b1, kv_db_pkg::COMMAND_UNSET, KEY_W'(3), '0);
        issue(1'b0, kv_db_pkg::COMMAND_GET, KEY_W'(3), '0);
        issue(1'b1, kv_db_pkg::COMMAND_SET, KEY_W'(5), 32'h5555_aaaa);
        issue(1'b0, kv_db_pkg::COMMAND_NOP, KEY_W'(5), 32'hdead_beef);
        issue(1'b1, kv_db_pkg::COMMAND_GET, KEY_W'(5), '0);
        // Same-cycle requests, hi goes first
        fork
            issue(1'b0, kv_db_pkg::COMMAND_SET, KEY_W'(6), 32'h0000_0066);
            issue(1'b1, kv_db_pkg::COMMAND_GET, KEY_W'(6), '0);
        join

        // ==============================
        // Random traffic on both ports
        // ==============================

        for (int n = 0; n < RANDOM_OPS; n++) begin
            pick(hi_cmd, hi_k, hi_v, hi_gap);
            pick(lo_cmd, lo_k, lo_v, lo_gap);
            fork
                begin
                    repeat (hi_gap) @(negedge clk);
                    issue(1'b0, hi_cmd, hi_k, hi_v);
                end
                begin
                    repeat (lo_gap) @(negedge clk);
                    issue(1'b1, lo_cmd, lo_k, lo_v);
                end
            join
        end

        // CLEAR empties rows that were set
        issue(1'b0, kv_db_pkg::COMMAND_SET, KEY_W'(1), 32'h0000_0011);
        issue(1'b1, kv_db_pkg::COMMAND_SET, KEY_W'(2), 32'h0000_0022);
        issue(1'b0, kv_db_pkg::COMMAND_CLEAR, '0, '0);
        issue(1'b1, kv_db_pkg::COMMAND_GET, KEY_W'(1), '0);
        issue(1'b0, kv_db_pkg::COMMAND_GET, KEY_W'(2), '0);

        repeat (4) @(negedge clk);
        assert_fails = UUT.u_prio_arb.u_assertions.fail_count;
        $display("Tests: %0d  mismatches: %0d  timeouts: %0d  assertion failures: %0d",
                 checks_done, error_count, timeouts, assert_fails);
        if (checks_done > 0 && error_count == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : kv_db_tb

/* kv_db_top.sv */
// Top level of the key-value table: priority arbiter in front of the table store, widths set here
`timescale 1ns/100ps

module kv_db_top #(
    parameter int KEY_W   = kv_db_pkg::KEY_W_DEFAULT,
    parameter int VALUE_W = kv_db_pkg::VALUE_W_DEFAULT
) (
    input  logic                clk,
    input  logic                srst,
    // High-priority controller
    input  logic                hi_req,
    input  kv_db_pkg::command_t hi_command,
    input  logic [KEY_W-1:0]    hi_key,
    input  logic [VALUE_W-1:0]  hi_set_value,
    output logic                hi_rdy,
    output logic                hi_ack,
    // Low-priority controller
    input  logic                lo_req,
    input  kv_db_pkg::command_t lo_command,
    input  logic [KEY_W-1:0]    lo_key,
    input  logic [VALUE_W-1:0]  lo_set_value,
    output logic                lo_rdy,
    output logic                lo_ack,
    // Shared response, qualified by each port's ack
    output kv_db_pkg::status_t  status,
    output logic                get_valid,
    output logic [KEY_W-1:0]    get_key,
    output logic [VALUE_W-1:0]  get_value
);

    // ==============================
    // Arbiter to store
    // ==============================

    logic                st_req;
    kv_db_pkg::command_t st_command;
    logic [KEY_W-1:0]    st_key;
    logic [VALUE_W-1:0]  st_set_value;
    logic                st_rdy;
    logic                st_ack;
    kv_db_pkg::status_t  st_status;
    logic                st_get_valid;
    logic [KEY_W-1:0]    st_get_key;
    logic [VALUE_W-1:0]  st_get_value;

    kv_db_prio_arb #(
        .KEY_W   (KEY_W),
        .VALUE_W (VALUE_W)
    ) u_prio_arb (
        .clk          (clk),
        .srst         (srst),
        .hi_req       (hi_req),
        .hi_command   (hi_command),
        .hi_key       (hi_key),
        .hi_set_value (hi_set_value),
        .hi_rdy       (hi_rdy),
        .hi_ack       (hi_ack),
        .lo_req       (lo_req),
        .lo_command   (lo_command),
        .lo_key       (lo_key),
        .lo_set_value (lo_set_value),
        .lo_rdy       (lo_rdy),
        .lo_ack       (lo_ack),
        .st_req       (st_req),
        .st_command   (st_command),
        .st_key       (st_key),
        .st_set_value (st_set_value),
        .st_rdy       (st_rdy),
        .st_ack       (st_ack),
        .st_status    (st_status),
        .st_get_valid (st_get_valid),
        .st_get_key   (st_get_key),
        .st_get_value (st_get_value),
        .status       (status),
        .get_valid    (get_valid),
        .get_key      (get_key),
        .get_value    (get_value)
    );

    kv_db_store #(
        .KEY_W   (KEY_W),
        .VALUE_W (VALUE_W)
    ) u_store (
        .clk       (clk),
        .srst      (srst),
        .req       (st_req),
        .command   (st_command),
        .key       (st_key),
        .set_value (st_set_value),
        .rdy       (st_rdy),
        .ack       (st_ack),
        .status    (st_status),
        .get_valid (st_get_valid),
        .get_key   (st_get_key),
        .get_value (st_get_value)
    );

endmodule : kv_db_top
